/* Bender.yml */
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - cpu_if.sv
  - cpu_register_file.sv
  - cpu_fetch.sv
  - cpu_decode.sv
  - cpu_execute.sv
  - cpu_writeback.sv
  - cpu_forward_ctrl.sv
  - cpu_branch_ctrl.sv
  - cpu.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_cpu.sv

/* cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W,
	parameter int IDX_W  = REG_W,
	parameter int N_REGS = NUM_REGS
) (
	input  logic                          clk,
	input  logic                          i_arst_n,

	output logic [DATA_W-1:0]             o_pc_addr,
	output logic                          o_pc_rd,
	input  logic [DATA_W-1:0]             i_pc_rddata,

	output logic [DATA_W-1:0]             o_ldst_addr,
	output logic                          o_ldst_rd,
	output logic                          o_ldst_wr,
	output logic [DATA_W-1:0]             o_ldst_wrdata,
	input  logic [DATA_W-1:0]             i_ldst_rddata,

	output logic [N_REGS-1:0][DATA_W-1:0] o_tb_regs
);

	logic [IDX_W-1:0]  rx;
	logic [IDX_W-1:0]  ry;
	logic [DATA_W-1:0] rx_data;
	logic [DATA_W-1:0] ry_data;
	logic              rw_en;
	logic [IDX_W-1:0]  rw;
	logic [DATA_W-1:0] rw_data;

	logic              br_en;
	logic [DATA_W-1:0] br_pc;
	logic [DATA_W-1:0] s2_pc;

	logic [DATA_W-1:0] s3_pc;
	logic [DATA_W-1:0] s3_ir;
	logic              s3_valid;
	logic              flag_n;
	logic              flag_z;

	logic [DATA_W-1:0] s4_ir;
	logic [DATA_W-1:0] s4_g;
	logic              s4_valid;

	cpu_de_if #(.DATA_W(DATA_W), .IDX_W(IDX_W)) de_bus ();
	cpu_fwd_if #(.DATA_W(DATA_W)) fwd_bus ();

	cpu_register_file #(.DATA_W(DATA_W), .IDX_W(IDX_W), .N_REGS(N_REGS)) registers (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_rx(rx),
		.i_ry(ry),
		.i_rw_en(rw_en),
		.i_rw(rw),
		.i_rw_data(rw_data),
		.o_rx_data(rx_data),
		.o_ry_data(ry_data),
		.o_regs(o_tb_regs)
	);

	cpu_fetch #(.DATA_W(DATA_W)) s1_fetch (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_br_en(br_en),
		.i_br_pc(br_pc),
		.o_pc_addr(o_pc_addr),
		.o_pc_rd(o_pc_rd),
		.o_pc(s2_pc)
	);

	// Instruction word comes straight from the memory port
	cpu_decode #(.DATA_W(DATA_W), .IDX_W(IDX_W)) s2_decode (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_pc(s2_pc),
		.i_ir(i_pc_rddata),
		.i_br_en(br_en),
		.i_rx_data(rx_data),
		.i_ry_data(ry_data),
		.o_rx(rx),
		.o_ry(ry),
		.de(de_bus.src)
	);

	cpu_execute #(.DATA_W(DATA_W)) s3_execute (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.de(de_bus.sink),
		.fwd(fwd_bus.sink),
		.o_ir(s4_ir),
		.o_g(s4_g),
		.o_valid(s4_valid),
		.o_n(flag_n),
		.o_z(flag_z),
		.o_pc(s3_pc),
		.o_s3_ir(s3_ir),
		.o_s3_valid(s3_valid),
		.o_mem_addr(o_ldst_addr),
		.o_mem_wrdata(o_ldst_wrdata),
		.o_mem_rd(o_ldst_rd),
		.o_mem_wr(o_ldst_wr)
	);

	cpu_writeback #(.DATA_W(DATA_W), .IDX_W(IDX_W)) s4_writeback (
		.i_ir(s4_ir),
		.i_g(s4_g),
		.i_valid(s4_valid),
		.i_mem_rddata(i_ldst_rddata),
		.o_rw_en(rw_en),
		.o_rw(rw),
		.o_rw_data(rw_data)
	);

	cpu_forward_ctrl #(.DATA_W(DATA_W), .IDX_W(IDX_W)) forward_control (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.de(de_bus.monitor),
		.i_rw_en(rw_en),
		.i_rw(rw),
		.i_rw_data(rw_data),
		.fwd(fwd_bus.src)
	);

	cpu_branch_ctrl #(.DATA_W(DATA_W)) branch_control (
		.i_s3_valid(s3_valid),
		.i_s3_ir(s3_ir),
		.i_s3_pc(s3_pc),
		.i_n(flag_n),
		.i_z(flag_z),
		.o_br_en(br_en),
		.o_br_pc(br_pc)
	);

endmodule

/* cpu_branch_ctrl.sv */
`timescale 1ns/1ps

module cpu_branch_ctrl import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W
) (
	input  logic              i_s3_valid,
	input  logic [DATA_W-1:0] i_s3_ir,
	input  logic [DATA_W-1:0] i_s3_pc,
	input  logic              i_n,
	input  logic              i_z,
	output logic              o_br_en,
	output logic [DATA_W-1:0] o_br_pc
);

	cpu_op_e op;
	logic    is_jump;
	logic    taken;

	assign op = op_of(i_s3_ir);

	// Flags still hold the state left by the previous instruction
	always_comb begin
		is_jump = 1'b1;
		taken   = 1'b0;
		case (op)
			OP_J:    taken = 1'b1;
			OP_JZ:   taken = i_z;
			OP_JN:   taken = i_n;
			default: is_jump = 1'b0;
		endcase
	end

	assign o_br_en = i_s3_valid & taken;
	assign o_br_pc = i_s3_pc + DATA_W'(1) + imm_of(i_s3_ir);

	a_br_jump: assert final (!o_br_en || (i_s3_valid && is_jump));

endmodule

/* cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W,
	parameter int IDX_W  = REG_W
) (
	input  logic              clk,
	input  logic              i_arst_n,
	input  logic [DATA_W-1:0] i_pc,
	input  logic [DATA_W-1:0] i_ir,
	input  logic              i_br_en,
	input  logic [DATA_W-1:0] i_rx_data,
	input  logic [DATA_W-1:0] i_ry_data,
	output logic [IDX_W-1:0]  o_rx,
	output logic [IDX_W-1:0]  o_ry,
	cpu_de_if.src             de
);

	logic fetch_valid;
	logic drop_next;
	logic word_valid;

	assign o_rx = rx_of(i_ir);
	assign o_ry = ry_of(i_ir);

	// A taken jump kills the word in decode now and the one issued alongside it
	assign word_valid = fetch_valid & ~drop_next & ~i_br_en;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			fetch_valid <= 1'b0;
			drop_next   <= 1'b0;
			de.valid    <= 1'b0;
		end else begin
			fetch_valid <= 1'b1;
			drop_next   <= i_br_en;
			de.valid    <= word_valid;
		end
	end

	always_ff @(posedge clk) begin
		de.pc <= i_pc;
		de.ir <= i_ir;
		de.a  <= i_rx_data;
		de.b  <= i_ry_data;
		de.rx <= o_rx;
		de.ry <= o_ry;
	end

endmodule

/* cpu_execute.sv */
`timescale 1ns/1ps

module cpu_execute import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W
) (
	input  logic              clk,
	input  logic              i_arst_n,
	cpu_de_if.sink            de,
	cpu_fwd_if.sink           fwd,
	output logic [DATA_W-1:0] o_ir,
	output logic [DATA_W-1:0] o_g,
	output logic              o_valid,
	output logic              o_n,
	output logic              o_z,
	output logic [DATA_W-1:0] o_pc,
	output logic [DATA_W-1:0] o_s3_ir,
	output logic              o_s3_valid,
	output logic [DATA_W-1:0] o_mem_addr,
	output logic [DATA_W-1:0] o_mem_wrdata,
	output logic              o_mem_rd,
	output logic              o_mem_wr
);

	cpu_op_e           op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] imm;
	logic [DATA_W-1:0] g;
	logic              set_flags;

	function automatic logic [DATA_W-1:0] pick(input cpu_fwd_sel_e sel,
		input logic [DATA_W-1:0] rd, input logic [DATA_W-1:0] cur,
		input logic [DATA_W-1:0] prev);
		case (sel)
			FWD_CUR:  return cur;
			FWD_PREV: return prev;
			default:  return rd;
		endcase
	endfunction

	assign op  = op_of(de.ir);
	assign imm = imm_of(de.ir);
	assign a   = pick(fwd.sel_a, de.a, fwd.cur_data, fwd.prev_data);
	assign b   = pick(fwd.sel_b, de.b, fwd.cur_data, fwd.prev_data);

	always_comb begin
		g         = b;
		set_flags = 1'b0;
		case (op)
			OP_ADD: begin
				g         = a + b;
				set_flags = 1'b1;
			end
			OP_SUB, OP_CMP: begin
				g         = a - b;
				set_flags = 1'b1;
			end
			OP_MVI:  g = imm;
			OP_ADDI: begin
				g         = a + imm;
				set_flags = 1'b1;
			end
			default: g = b;
		endcase
	end

	// ld rX,[rY] and st rX,[rY]
	assign o_mem_rd     = de.valid && op == OP_LD;
	assign o_mem_wr     = de.valid && op == OP_ST;
	assign o_mem_addr   = b;
	assign o_mem_wrdata = a;

	assign o_pc       = de.pc;
	assign o_s3_ir    = de.ir;
	assign o_s3_valid = de.valid;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_n     <= 1'b0;
			o_z     <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			if (de.valid && set_flags) begin
				o_n <= g[DATA_W-1];
				o_z <= g == '0;
			end
			o_valid <= de.valid;
		end
	end

	always_ff @(posedge clk) begin
		o_ir <= de.ir;
		o_g  <= g;
	end

	a_strobes: assert property (@(posedge clk) disable iff (!i_arst_n)
		!(o_mem_rd && o_mem_wr));

endmodule

/* cpu_fetch.sv */
`timescale 1ns/1ps

module cpu_fetch import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W
) (
	input  logic              clk,
	input  logic              i_arst_n,
	input  logic              i_br_en,
	input  logic [DATA_W-1:0] i_br_pc,
	output logic [DATA_W-1:0] o_pc_addr,
	output logic              o_pc_rd,
	output logic [DATA_W-1:0] o_pc
);

	logic [DATA_W-1:0] pc;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc <= '0;
		end else begin
			pc <= i_br_en ? i_br_pc : pc + DATA_W'(1);
		end
	end

	// Lines up with the word returned by the memory
	always_ff @(posedge clk) begin
		o_pc <= pc;
	end

	assign o_pc_addr = pc;
	// No wait states, so a read goes out every cycle
	assign o_pc_rd   = 1'b1;

	a_pc_rd: assert property (@(posedge clk) disable iff (!i_arst_n) o_pc_rd);

endmodule

/* cpu_forward_ctrl.sv */
`timescale 1ns/1ps

module cpu_forward_ctrl import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W,
	parameter int IDX_W  = REG_W
) (
	input  logic              clk,
	input  logic              i_arst_n,
	cpu_de_if.monitor         de,
	input  logic              i_rw_en,
	input  logic [IDX_W-1:0]  i_rw,
	input  logic [DATA_W-1:0] i_rw_data,
	cpu_fwd_if.src            fwd
);

	logic              prev_en;
	logic [IDX_W-1:0]  prev_rw;
	logic [DATA_W-1:0] prev_data;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			prev_en <= 1'b0;
		end else begin
			prev_en <= i_rw_en;
		end
	end

	always_ff @(posedge clk) begin
		prev_rw   <= i_rw;
		prev_data <= i_rw_data;
	end

	// Newest write wins
	always_comb begin
		fwd.sel_a = FWD_NONE;
		fwd.sel_b = FWD_NONE;
		if (i_rw_en && i_rw == de.rx) begin
			fwd.sel_a = FWD_CUR;
		end else if (prev_en && prev_rw == de.rx) begin
			fwd.sel_a = FWD_PREV;
		end
		if (i_rw_en && i_rw == de.ry) begin
			fwd.sel_b = FWD_CUR;
		end else if (prev_en && prev_rw == de.ry) begin
			fwd.sel_b = FWD_PREV;
		end
	end

	assign fwd.cur_data  = i_rw_data;
	assign fwd.prev_data = prev_data;

	a_cur_en: assert property (@(posedge clk) disable iff (!i_arst_n)
		(fwd.sel_a == FWD_CUR || fwd.sel_b == FWD_CUR) |-> i_rw_en);

endmodule

/* cpu_if.sv */
`timescale 1ns/1ps

interface cpu_de_if import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W,
	parameter int IDX_W  = REG_W
);
	logic              valid;
	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] ir;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [IDX_W-1:0]  rx;
	logic [IDX_W-1:0]  ry;

	modport src (output valid, pc, ir, a, b, rx, ry);
	modport sink (input valid, pc, ir, a, b);
	// Forwarding only needs the source register indices
	modport monitor (input rx, ry);
endinterface

interface cpu_fwd_if import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W
);
	cpu_fwd_sel_e      sel_a;
	cpu_fwd_sel_e      sel_b;
	logic [DATA_W-1:0] cur_data;
	logic [DATA_W-1:0] prev_data;

	modport src (output sel_a, sel_b, cur_data, prev_data);
	modport sink (input sel_a, sel_b, cur_data, prev_data);
endinterface

/* cpu_pkg.sv */
package cpu_pkg;

	localparam int WORD_W   = 16;
	localparam int REG_W    = 3;
	localparam int NUM_REGS = 8;

	// Instruction field positions
	localparam int OP_LSB  = 0;
	localparam int OP_MSB  = 3;
	localparam int RX_LSB  = 5;
	localparam int RX_MSB  = 7;
	localparam int RY_LSB  = 8;
	localparam int RY_MSB  = 10;
	localparam int IMM_LSB = 8;
	localparam int IMM_MSB = 15;
	localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

	// Codes 4'hb to 4'hf execute as no-operation
	typedef enum logic [3:0] {
		OP_MV   = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_CMP  = 4'h3,
		OP_LD   = 4'h4,
		OP_ST   = 4'h5,
		OP_MVI  = 4'h6,
		OP_ADDI = 4'h7,
		OP_J    = 4'h8,
		OP_JZ   = 4'h9,
		OP_JN   = 4'ha
	} cpu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_CUR  = 2'd1,
		FWD_PREV = 2'd2
	} cpu_fwd_sel_e;

	function automatic cpu_op_e op_of(input logic [WORD_W-1:0] ir);
		return cpu_op_e'(ir[OP_MSB:OP_LSB]);
	endfunction

	function automatic logic [REG_W-1:0] rx_of(input logic [WORD_W-1:0] ir);
		return ir[RX_MSB:RX_LSB];
	endfunction

	function automatic logic [REG_W-1:0] ry_of(input logic [WORD_W-1:0] ir);
		return ir[RY_MSB:RY_LSB];
	endfunction

	// Sign-extended to a full word
	function automatic logic [WORD_W-1:0] imm_of(input logic [WORD_W-1:0] ir);
		return {{(WORD_W - IMM_W){ir[IMM_MSB]}}, ir[IMM_MSB:IMM_LSB]};
	endfunction

endpackage

/* cpu_register_file.sv */
`timescale 1ns/1ps

module cpu_register_file import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W,
	parameter int IDX_W  = REG_W,
	parameter int N_REGS = NUM_REGS
) (
	input  logic                          clk,
	input  logic                          i_arst_n,
	input  logic [IDX_W-1:0]              i_rx,
	input  logic [IDX_W-1:0]              i_ry,
	input  logic                          i_rw_en,
	input  logic [IDX_W-1:0]              i_rw,
	input  logic [DATA_W-1:0]             i_rw_data,
	output logic [DATA_W-1:0]             o_rx_data,
	output logic [DATA_W-1:0]             o_ry_data,
	output logic [N_REGS-1:0][DATA_W-1:0] o_regs
);

	logic [N_REGS-1:0][DATA_W-1:0] regs;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			regs <= '0;
		end else if (i_rw_en) begin
			regs[i_rw] <= i_rw_data;
		end
	end

	// Old value on a same-cycle write, forwarding fixes it up later
	assign o_rx_data = regs[i_rx];
	assign o_ry_data = regs[i_ry];
	assign o_regs    = regs;

endmodule

/* cpu_writeback.sv */
`timescale 1ns/1ps

module cpu_writeback import cpu_pkg::*; #(
	parameter int DATA_W = WORD_W,
	parameter int IDX_W  = REG_W
) (
	input  logic [DATA_W-1:0] i_ir,
	input  logic [DATA_W-1:0] i_g,
	input  logic              i_valid,
	input  logic [DATA_W-1:0] i_mem_rddata,
	output logic              o_rw_en,
	output logic [IDX_W-1:0]  o_rw,
	output logic [DATA_W-1:0] o_rw_data
);

	cpu_op_e op;
	logic    writes;

	assign op = op_of(i_ir);

	always_comb begin
		case (op)
			OP_MV, OP_ADD, OP_SUB, OP_MVI, OP_ADDI, OP_LD: writes = 1'b1;
			default: writes = 1'b0;
		endcase
	end

	assign o_rw_en   = i_valid & writes;
	assign o_rw      = rx_of(i_ir);
	// Memory answers one cycle after the strobe, i.e. right now
	assign o_rw_data = (op == OP_LD) ? i_mem_rddata : i_g;

endmodule

/* list.f */
cpu_pkg.sv
cpu_if.sv
cpu_register_file.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_writeback.sv
cpu_forward_ctrl.sv
cpu_branch_ctrl.sv
cpu.sv
tb_clock.sv
tb_cpu.sv

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS    = 8.0,
	parameter int  RESET_CYCLES = 3
) (
	input  logic i_reset_req,
	output logic o_clk,
	output logic o_arst_n
);

	int count = RESET_CYCLES;

	initial begin
		o_clk    = 1'b0;
		o_arst_n <= 1'b0;
	end

	always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

	// Reset moves on the falling edge so it is settled at every rising edge
	always @(negedge o_clk) begin
		if (i_reset_req) begin
			count    <= RESET_CYCLES;
			o_arst_n <= 1'b0;
		end else if (count != 0) begin
			count    <= count - 1;
			o_arst_n <= (count == 1);
		end
	end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; #(
	parameter int ROUNDS   = 4,
	parameter int PROG_LEN = 48
) ();

	localparam int                MEM_WORDS       = 256;
	localparam int unsigned       SEED            = 32'h8ccda2fa;
	localparam int                MAX_JUMP        = 3;
	localparam int                HALT_SHOWINGS   = 4;
	// 60 instructions of 4 cycles each per round
	localparam int                WATCHDOG_CYCLES = ROUNDS * 60 * 4;
	localparam logic [WORD_W-1:0] HALT_ADDR       = WORD_W'(PROG_LEN);

	logic                            clk;
	logic                            arst_n;
	logic                            reset_req = 1'b0;
	logic [WORD_W-1:0]               pc_addr;
	logic                            pc_rd;
	logic [WORD_W-1:0]               pc_rddata = '0;
	logic [WORD_W-1:0]               ldst_addr;
	logic                            ldst_rd;
	logic                            ldst_wr;
	logic [WORD_W-1:0]               ldst_wrdata;
	logic [WORD_W-1:0]               ldst_rddata = '0;
	logic [NUM_REGS-1:0][WORD_W-1:0] tb_regs;

	logic [WORD_W-1:0]               imem [MEM_WORDS];
	logic [WORD_W-1:0]               init_dmem [MEM_WORDS];
	logic [WORD_W-1:0]               dmem [MEM_WORDS];
	logic [WORD_W-1:0]               model_dmem [MEM_WORDS];
	logic [NUM_REGS-1:0][WORD_W-1:0] exp_regs;
	logic [WORD_W-1:0]               exp_store_addr [$];
	logic [WORD_W-1:0]               exp_store_data [$];

	tb_clock #(.PERIOD_NS(8.0), .RESET_CYCLES(3)) clock_gen (
		.i_reset_req(reset_req),
		.o_clk(clk),
		.o_arst_n(arst_n)
	);

	cpu #(.DATA_W(WORD_W), .IDX_W(REG_W), .N_REGS(NUM_REGS)) i_dut (
		.clk(clk),
		.i_arst_n(arst_n),
		.o_pc_addr(pc_addr),
		.o_pc_rd(pc_rd),
		.i_pc_rddata(pc_rddata),
		.o_ldst_addr(ldst_addr),
		.o_ldst_rd(ldst_rd),
		.o_ldst_wr(ldst_wr),
		.o_ldst_wrdata(ldst_wrdata),
		.i_ldst_rddata(ldst_rddata),
		.o_tb_regs(tb_regs)
	);

	always @(posedge clk) begin
		if (pc_rd) begin
			pc_rddata <= imem[pc_addr[7:0]];
		end
	end

	// Data memory takes the round image while reset is held
	always @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				dmem[i] <= init_dmem[i];
			end
		end else begin
			if (ldst_wr) begin
				dmem[ldst_addr[7:0]] <= ldst_wrdata;
			end
			if (ldst_rd) begin
				ldst_rddata <= dmem[ldst_addr[7:0]];
			end
		end
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string msg);
		stop_run($sformatf("Mismatch at %0d ns: %s", $time, msg));
	endtask

	task automatic check_store(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [WORD_W-1:0] want_addr;
		logic [WORD_W-1:0] want_data;
		if (exp_store_addr.size() == 0) begin
			report_mismatch($sformatf("unexpected store of %h to %h", data, addr));
		end else begin
			want_addr = exp_store_addr.pop_front();
			want_data = exp_store_data.pop_front();
			if (addr !== want_addr || data !== want_data) begin
				report_mismatch($sformatf("store of %h to %h, expected %h to %h",
					data, addr, want_data, want_addr));
			end
		end
	endtask

	task automatic check_regs(input logic [NUM_REGS-1:0][WORD_W-1:0] expected,
		input string what);
		for (int r = 0; r < NUM_REGS; r++) begin
			if (tb_regs[r] !== expected[r]) begin
				report_mismatch($sformatf("%s r%0d is %h, expected %h",
					what, r, tb_regs[r], expected[r]));
			end
		end
	endtask

	task automatic check_reset_outputs(input string what);
		if (pc_rd !== 1'b1) begin
			report_mismatch($sformatf("%s o_pc_rd is %b, expected 1", what, pc_rd));
		end
		if (pc_addr !== '0) begin
			report_mismatch($sformatf("%s o_pc_addr is %h, expected 0", what, pc_addr));
		end
		if (ldst_rd !== 1'b0 || ldst_wr !== 1'b0) begin
			report_mismatch($sformatf("%s data strobes rd %b wr %b, expected low",
				what, ldst_rd, ldst_wr));
		end
		check_regs('0, what);
	endtask

	function automatic logic [WORD_W-1:0] random_instr(input int addr);
		cpu_op_e          op;
		logic [REG_W-1:0] rx;
		logic [REG_W-1:0] ry;
		logic [7:0]       imm;
		int               reach;
		op  = cpu_op_e'($urandom_range(10, 0));
		rx  = REG_W'($urandom);
		ry  = REG_W'($urandom);
		imm = 8'($urandom);
		case (op)
			OP_MVI, OP_ADDI: return {imm, rx, 1'b0, op};
			OP_J, OP_JZ, OP_JN: begin
				// Forward only and never past the halt
				reach = PROG_LEN - 1 - addr;
				if (reach > MAX_JUMP) begin
					reach = MAX_JUMP;
				end
				imm = 8'($urandom_range(reach, 0));
				return {imm, 3'b000, 1'b0, op};
			end
			default: return {5'b00000, ry, rx, 1'b0, op};
		endcase
	endfunction

	task automatic load_round();
		for (int a = 0; a < MEM_WORDS; a++) begin
			init_dmem[a] = WORD_W'($urandom);
			if (a < PROG_LEN) begin
				imem[a] = random_instr(a);
			end else if (a == PROG_LEN) begin
				// Offset of -1 lands on the jump itself
				imem[a] = {8'hff, 4'h0, OP_J};
			end else begin
				imem[a] = WORD_W'($urandom);
			end
		end
	endtask

	// Instruction set model that runs one instruction at a time
	task automatic run_model();
		logic [WORD_W-1:0] pc;
		logic [WORD_W-1:0] ir;
		logic [WORD_W-1:0] x;
		logic [WORD_W-1:0] y;
		logic [WORD_W-1:0] res;
		logic              flag_n;
		logic              flag_z;
		logic              set_flags;
		pc       = '0;
		flag_n   = 1'b0;
		flag_z   = 1'b0;
		exp_regs = '0;
		exp_store_addr.delete();
		exp_store_data.delete();
		for (int a = 0; a < MEM_WORDS; a++) begin
			model_dmem[a] = init_dmem[a];
		end
		while (pc != HALT_ADDR) begin
			ir        = imem[pc[7:0]];
			x         = exp_regs[rx_of(ir)];
			y         = exp_regs[ry_of(ir)];
			res       = '0;
			set_flags = 1'b0;
			pc        = pc + 1'b1;
			case (op_of(ir))
				OP_MV: exp_regs[rx_of(ir)] = y;
				OP_ADD: begin
					res                 = x + y;
					exp_regs[rx_of(ir)] = res;
					set_flags           = 1'b1;
				end
				OP_SUB: begin
					res                 = x - y;
					exp_regs[rx_of(ir)] = res;
					set_flags           = 1'b1;
				end
				OP_CMP: begin
					res       = x - y;
					set_flags = 1'b1;
				end
				OP_LD: exp_regs[rx_of(ir)] = model_dmem[y[7:0]];
				OP_ST: begin
					model_dmem[y[7:0]] = x;
					exp_store_addr.push_back(y);
					exp_store_data.push_back(x);
				end
				OP_MVI: exp_regs[rx_of(ir)] = imm_of(ir);
				OP_ADDI: begin
					res                 = x + imm_of(ir);
					exp_regs[rx_of(ir)] = res;
					set_flags           = 1'b1;
				end
				OP_J: pc = pc + imm_of(ir);
				OP_JZ: begin
					if (flag_z) begin
						pc = pc + imm_of(ir);
					end
				end
				OP_JN: begin
					if (flag_n) begin
						pc = pc + imm_of(ir);
					end
				end
				default: ;
			endcase
			if (set_flags) begin
				flag_n = res[WORD_W-1];
				flag_z = (res == '0);
			end
		end
	endtask

	task automatic start_round();
		reset_req <= 1'b1;
		@(negedge clk);
		load_round();
		run_model();
		@(posedge clk);
		reset_req <= 1'b0;
		while (!arst_n) begin
			check_reset_outputs("during reset");
			@(posedge clk);
		end
		check_reset_outputs("first cycle after reset");
	endtask

	task automatic wait_for_halt();
		int seen;
		seen = 0;
		while (seen < HALT_SHOWINGS) begin
			@(posedge clk);
			if (pc_addr == HALT_ADDR) begin
				seen++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (arst_n && ldst_wr) begin
			check_store(ldst_addr, ldst_wrdata);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_run("Timeout: the rounds did not finish within the cycle budget");
	end

	initial begin
		void'($urandom(SEED));
		for (int round = 0; round < ROUNDS; round++) begin
			@(posedge clk);
			start_round();
			wait_for_halt();
			if (exp_store_addr.size() != 0) begin
				stop_run($sformatf("Round %0d ended with %0d expected stores never seen",
					round, exp_store_addr.size()));
			end
			check_regs(exp_regs, $sformatf("round %0d final", round));
		end
		$display("test passed");
		$finish;
	end

endmodule
